//--- rtl/s16b_pkg.sv
// ####################
// Shared types and constants for the System 16B main board decoder.
// Modules import it inside their body and use scoped names in ports.
// ####################
package s16b_pkg;

    // CPU word address, byte lane selected by the data strobes
    typedef logic [23:1] addr_t;

    typedef logic [15:0] word_t;
    typedef logic [7:0]  byte_t;

    // Program ROM word address as seen by the SDRAM
    typedef logic [18:1] rom_addr_t;

    // One-hot region lines coming from the bus mapper
    typedef logic [7:0] region_t;

    // Two three-bit halves, selected by address bit 1
    typedef logic [5:0] tile_bank_t;

    // Board families that change the ROM layout
    typedef enum logic [2:0] {
        BOARD_5521       = 3'd0,  // also 5704
        BOARD_5358_SMALL = 3'd1,
        BOARD_5358_LARGE = 3'd2,
        BOARD_5797       = 3'd3,
        BOARD_KOREAN     = 3'd4
    } board_t;

    // Mapper region numbers
    // Regions 0 to 2 hold program ROM or board specific devices
    localparam int REG_RAM  = 3;
    localparam int REG_ORAM = 4;
    localparam int REG_VRAM = 5;
    localparam int REG_PAL  = 6;
    localparam int REG_IO   = 7;

    // Data returned when no device answers
    localparam word_t OPEN_BUS = 16'hffff;

    // I/O reads are byte wide, upper lane floats high
    localparam byte_t IO_HIGH_BYTE = 8'hff;

    // Game ids fitted with the large 5358 board
    localparam byte_t BOARD_5358L_IDS [3] = '{
        8'h10,
        8'h15,
        8'h1a
    };

endpackage

//--- rtl/s16b_board_map.sv
// ####################
// Board family detection from the game id and program ROM
// address mapping for each family's ROM layout.
// ####################
`timescale 1ns/1ps

module s16b_board_map (
    input  logic                  clk,
    input  logic                  rst,
    input  s16b_pkg::byte_t       game_id,
    input  s16b_pkg::region_t     active,
    input  s16b_pkg::addr_t       addr,
    output s16b_pkg::board_t      board,
    output s16b_pkg::rom_addr_t   rom_addr
);
    import s16b_pkg::*;

    board_t    board_next;
    logic      is_large;
    logic [1:0] bank;

    // Large 5358 boards are told apart by id only
    always_comb begin
        is_large = 1'b0;
        foreach (BOARD_5358L_IDS[i]) begin
            if (game_id == BOARD_5358L_IDS[i]) begin
                is_large = 1'b1;
            end
        end
    end

    always_comb begin
        if (game_id[5]) begin
            board_next = BOARD_5797;
        end else if (game_id[7:4] == 4'b0001) begin
            board_next = is_large ? BOARD_5358_LARGE : BOARD_5358_SMALL;
        end else if (game_id[7:3] == 5'b00001) begin
            board_next = BOARD_KOREAN;
        end else begin
            board_next = BOARD_5521;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            board <= BOARD_5521;
        end else begin
            board <= board_next;
        end
    end

    // ROM bank from the low region lines
    always_comb begin
        case (active[2:0])
            3'b001:  bank = 2'd0;
            3'b010:  bank = 2'd1;
            3'b100:  bank = 2'd2;
            default: bank = 2'd0;
        endcase
    end

    always_comb begin
        case (board)
            BOARD_5797:       rom_addr = addr[18:1];
            BOARD_5358_LARGE: rom_addr = {bank, addr[16:1]};
            BOARD_5358_SMALL: rom_addr = {1'b0, bank, addr[15:1]};
            BOARD_KOREAN:     rom_addr = {1'b0, addr[17:1]};
            default:          rom_addr = {bank[0], addr[17:1]};  // 512kB window
        endcase
    end

endmodule

//--- rtl/s16b_chip_select.sv
// ####################
// Registered chip selects for the System 16B memory map and
// SDRAM ready tracking that produces the bus_busy level.
// ####################
`timescale 1ns/1ps

module s16b_chip_select (
    input  logic                clk,
    input  logic                rst,
    input  s16b_pkg::board_t    board,
    input  s16b_pkg::region_t   active,
    input  s16b_pkg::addr_t     addr,
    input  logic                asn,
    input  logic                udsn,
    input  logic                ldsn,
    input  logic                rnw,
    input  logic                rom_ok,
    input  logic                ram_ok,
    output logic                rom_cs,
    output logic                ram_cs,
    output logic                vram_cs,
    output logic                char_cs,
    output logic                pal_cs,
    output logic                objram_cs,
    output logic                io_cs,
    output logic                tbank_cs,
    output logic                bus_busy
);
    import s16b_pkg::*;

    logic data_phase;
    logic decode_en;
    logic is_5797;
    logic sdram_ok;

    logic rom_next;
    logic ram_next;
    logic vram_next;
    logic char_next;
    logic pal_next;
    logic objram_next;
    logic io_next;
    logic tbank_next;

    assign data_phase = !udsn || !ldsn;
    // Reads may decode on the address strobe alone
    assign decode_en  = data_phase || (!asn && rnw);
    assign is_5797    = board == BOARD_5797;

    always_comb begin
        rom_next    = (is_5797 ? active[0] : |active[2:0]) && rnw;
        char_next   = active[REG_VRAM] && addr[16];
        // SDRAM requests need a toggle per access, so these
        // follow the data strobes and drop between RMW halves
        vram_next   = data_phase && active[REG_VRAM] && !addr[16];
        ram_next    = data_phase && active[REG_RAM];
        objram_next = active[REG_ORAM];
        pal_next    = active[REG_PAL];
        io_next     = active[REG_IO];
        if (is_5797) begin
            tbank_next = !rnw && active[1] && addr[13:12] == 2'd2;
        end else begin
            tbank_next = !rnw && active[2];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end else if (decode_en) begin
            rom_cs    <= rom_next;
            ram_cs    <= ram_next;
            vram_cs   <= vram_next;
            char_cs   <= char_next;
            pal_cs    <= pal_next;
            objram_cs <= objram_next;
            io_cs     <= io_next;
            tbank_cs  <= tbank_next;
        end else begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            tbank_cs  <= 1'b0;
        end
    end

    // Ready flag for the current SDRAM access
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sdram_ok <= 1'b0;
        end else if (asn) begin
            sdram_ok <= 1'b0;
        end else if (data_phase) begin
            sdram_ok <= rom_cs ? rom_ok : ram_ok;
        end
    end

    assign bus_busy = (rom_cs || ram_cs || vram_cs) && !sdram_ok;

endmodule

//--- rtl/s16b_data_bus.sv
// ####################
// Tile bank register and the registered read data mux that
// returns device data to the CPU.
// ####################
`timescale 1ns/1ps

module s16b_data_bus (
    input  logic                  clk,
    input  logic                  rst,
    input  s16b_pkg::addr_t       addr,
    input  s16b_pkg::word_t       cpu_dout,
    input  logic                  ldswn,
    input  logic                  rom_cs,
    input  logic                  ram_cs,
    input  logic                  vram_cs,
    input  logic                  char_cs,
    input  logic                  pal_cs,
    input  logic                  objram_cs,
    input  logic                  io_cs,
    input  logic                  tbank_cs,
    input  s16b_pkg::word_t       ram_data,
    input  s16b_pkg::word_t       rom_data,
    input  s16b_pkg::word_t       char_dout,
    input  s16b_pkg::word_t       pal_dout,
    input  s16b_pkg::word_t       obj_dout,
    input  s16b_pkg::byte_t       cab_dout,
    output s16b_pkg::word_t       cpu_din,
    output s16b_pkg::tile_bank_t  tile_bank
);
    import s16b_pkg::*;

    word_t din_next;

    // Only the low byte lane carries the bank value
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= '0;
        end else if (tbank_cs && !ldswn) begin
            if (addr[1]) begin
                tile_bank[5:3] <= cpu_dout[2:0];
            end else begin
                tile_bank[2:0] <= cpu_dout[2:0];
            end
        end
    end

    // Highest priority source first
    always_comb begin
        if (ram_cs || vram_cs) begin
            din_next = ram_data;
        end else if (rom_cs) begin
            din_next = rom_data;
        end else if (char_cs) begin
            din_next = char_dout;
        end else if (pal_cs) begin
            din_next = pal_dout;
        end else if (objram_cs) begin
            din_next = obj_dout;
        end else if (io_cs) begin
            din_next = {IO_HIGH_BYTE, cab_dout};
        end else begin
            din_next = OPEN_BUS;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else begin
            cpu_din <= din_next;
        end
    end

endmodule

//--- rtl/s16b_main.sv
// ####################
// Main board decoder top level. Sits between the bus mapper and
// the memories, joining board map, chip selects and data bus.
// ####################
`timescale 1ns/1ps

module s16b_main (
    input  logic                  clk,
    input  logic                  rst,
    input  s16b_pkg::byte_t       game_id,
    input  s16b_pkg::addr_t       addr,
    input  s16b_pkg::region_t     active,
    input  logic                  asn,
    input  logic                  udsn,
    input  logic                  ldsn,
    input  logic                  rnw,
    input  s16b_pkg::word_t       cpu_dout,
    input  s16b_pkg::word_t       ram_data,
    input  logic                  ram_ok,
    input  s16b_pkg::word_t       rom_data,
    input  logic                  rom_ok,
    input  s16b_pkg::word_t       char_dout,
    input  s16b_pkg::word_t       pal_dout,
    input  s16b_pkg::word_t       obj_dout,
    input  s16b_pkg::byte_t       cab_dout,
    output logic                  rom_cs,
    output s16b_pkg::rom_addr_t   rom_addr,
    output logic                  ram_cs,
    output logic                  vram_cs,
    output logic                  char_cs,
    output logic                  pal_cs,
    output logic                  objram_cs,
    output logic                  io_cs,
    output logic                  bus_busy,
    output s16b_pkg::word_t       cpu_din,
    output s16b_pkg::tile_bank_t  tile_bank,
    output logic                  udswn,
    output logic                  ldswn,
    output logic [12:1]           cpu_addr
);
    import s16b_pkg::*;

    board_t board;
    logic   tbank_cs;

    // Write strobes per byte lane
    assign udswn    = rnw || udsn;
    assign ldswn    = rnw || ldsn;
    // Peripheral address bus
    assign cpu_addr = addr[12:1];

    s16b_board_map board_map_i (
        .clk       (clk),
        .rst       (rst),
        .game_id   (game_id),
        .active    (active),
        .addr      (addr),
        .board     (board),
        .rom_addr  (rom_addr)
    );

    s16b_chip_select chip_select_i (
        .clk       (clk),
        .rst       (rst),
        .board     (board),
        .active    (active),
        .addr      (addr),
        .asn       (asn),
        .udsn      (udsn),
        .ldsn      (ldsn),
        .rnw       (rnw),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs),
        .bus_busy  (bus_busy)
    );

    s16b_data_bus data_bus_i (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .cpu_dout  (cpu_dout),
        .ldswn     (ldswn),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .pal_cs    (pal_cs),
        .objram_cs (objram_cs),
        .io_cs     (io_cs),
        .tbank_cs  (tbank_cs),
        .ram_data  (ram_data),
        .rom_data  (rom_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .cpu_din   (cpu_din),
        .tile_bank (tile_bank)
    );

endmodule

//--- sim/s16b_main_chk.sv
// ####################
// Concurrent assertions on the chip-select rules of the decoder.
// Bound into the top level from the testbench.
// ####################
`timescale 1ns/1ps

module s16b_main_chk (
    input logic clk,
    input logic rst,
    input logic asn,
    input logic udsn,
    input logic ldsn,
    input logic rnw,
    input logic rom_cs,
    input logic ram_cs,
    input logic vram_cs,
    input logic char_cs,
    input logic pal_cs,
    input logic objram_cs,
    input logic io_cs,
    input logic bus_busy
);

    logic any_cs;
    logic sdram_cs;

    assign any_cs   = rom_cs || ram_cs || vram_cs || char_cs || pal_cs || objram_cs || io_cs;
    assign sdram_cs = rom_cs || ram_cs || vram_cs;

    // ROM is read only
    rom_read_only: assert property (@(posedge clk) disable iff (rst) rom_cs |-> rnw)
        else $error("rom_cs set while rnw is low");

    char_vram_excl: assert property (@(posedge clk) disable iff (rst) !(char_cs && vram_cs))
        else $error("char_cs and vram_cs set together");

    // Idle bus clears every select
    idle_clears: assert property (@(posedge clk) disable iff (rst)
        $past(asn && udsn && ldsn) |-> !any_cs)
        else $error("chip select still set after an idle bus cycle");

    busy_needs_sdram: assert property (@(posedge clk) disable iff (rst) bus_busy |-> sdram_cs)
        else $error("bus_busy set without an SDRAM chip select");

endmodule

//--- sim/tb_s16b_main.sv
// ####################
// Testbench for the System 16B main board decoder. Drives mapper
// style bus cycles, models memory data and ok lines, and compares
// the DUT against reference functions at each falling clock edge.
// ####################
`timescale 1ns/1ps

module tb_s16b_main;
    import s16b_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int PLANNED_CYCLES = 500;
    localparam int MAX_WAIT       = 8;
    localparam int TIMEOUT_NS     = PLANNED_CYCLES * MAX_WAIT * CLK_PERIOD + 2000;

    logic       clk;
    logic       rst;
    byte_t      game_id;
    addr_t      addr;
    region_t    active;
    logic       asn;
    logic       udsn;
    logic       ldsn;
    logic       rnw;
    word_t      cpu_dout;
    word_t      ram_data;
    logic       ram_ok;
    word_t      rom_data;
    logic       rom_ok;
    word_t      char_dout;
    word_t      pal_dout;
    word_t      obj_dout;
    byte_t      cab_dout;
    logic       rom_cs;
    rom_addr_t  rom_addr;
    logic       ram_cs;
    logic       vram_cs;
    logic       char_cs;
    logic       pal_cs;
    logic       objram_cs;
    logic       io_cs;
    logic       bus_busy;
    word_t      cpu_din;
    tile_bank_t tile_bank;
    logic       udswn;
    logic       ldswn;
    logic [12:1] cpu_addr;

    // Expected values and their enables, read by the compare process
    logic [6:0] exp_cs;
    word_t      exp_din;
    rom_addr_t  exp_rom;
    logic       exp_busy;
    tile_bank_t exp_tbank;
    logic       cs_chk_en;
    logic       din_chk_en;
    logic       rom_chk_en;
    logic       busy_chk_en;
    logic       tbank_chk_en;
    board_t     cur_board;
    logic [31:0] lcg_state;
    int         err_count;
    logic [6:0] cs_vec;

    assign cs_vec = {io_cs, objram_cs, pal_cs, char_cs, vram_cs, ram_cs, rom_cs};

    s16b_main s16b_main_i (.*);

    bind s16b_main s16b_main_chk chk_i (
        .clk(clk), .rst(rst), .asn(asn), .udsn(udsn), .ldsn(ldsn), .rnw(rnw),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs), .bus_busy(bus_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic board_t board_class(byte_t id);
        if (id[5]) return BOARD_5797;
        if (id[7:4] == 4'b0001) begin
            if (id == 8'h10 || id == 8'h15 || id == 8'h1a) return BOARD_5358_LARGE;
            return BOARD_5358_SMALL;
        end
        if (id[7:3] == 5'b00001) return BOARD_KOREAN;
        return BOARD_5521;
    endfunction

    function automatic rom_addr_t rom_word_addr(board_t b, region_t act, addr_t a);
        logic [1:0] bank;
        bank = 2'd0;
        if (act[2:0] == 3'b010) bank = 2'd1;
        if (act[2:0] == 3'b100) bank = 2'd2;
        case (b)
            BOARD_5797:       return a[18:1];
            BOARD_5358_LARGE: return {bank, a[16:1]};
            BOARD_5358_SMALL: return {1'b0, bank, a[15:1]};
            BOARD_KOREAN:     return {1'b0, a[17:1]};
            default:          return {bank[0], a[17:1]};
        endcase
    endfunction

    // Order is io, objram, pal, char, vram, ram, rom
    function automatic logic [6:0] select_set(board_t b, region_t act, addr_t a,
                                              logic rd, logic ds);
        logic [6:0] cs;
        cs[0] = rd && ((b == BOARD_5797) ? act[0] : (act[2:0] != 3'b000));
        cs[1] = ds && act[3];
        cs[2] = ds && act[5] && !a[16];
        cs[3] = act[5] && a[16];
        cs[4] = act[6];
        cs[5] = act[4];
        cs[6] = act[7];
        return cs;
    endfunction

    function automatic word_t read_data_for(logic [6:0] cs);
        if (cs[1] || cs[2]) return ram_data;
        if (cs[0]) return rom_data;
        if (cs[3]) return char_dout;
        if (cs[4]) return pal_dout;
        if (cs[5]) return obj_dout;
        if (cs[6]) return {8'hff, cab_dout};
        return 16'hffff;
    endfunction

    function automatic logic tbank_write_hit(board_t b, region_t act, addr_t a);
        if (b == BOARD_5797) return act[1] && a[13:12] == 2'd2;
        return act[2];
    endfunction

    // Low only on a write with that lane's data strobe asserted
    function automatic logic write_strobe_n(logic rd, logic ds_n);
        if (!rd && !ds_n) begin
            return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            err_count = err_count + 1;
            $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (cs_chk_en) check("chip_selects", 32'(cs_vec), 32'(exp_cs));
        if (din_chk_en) check("cpu_din", 32'(cpu_din), 32'(exp_din));
        if (rom_chk_en) check("rom_addr", 32'(rom_addr), 32'(exp_rom));
        if (busy_chk_en) check("bus_busy", 32'(bus_busy), 32'(exp_busy));
        if (tbank_chk_en) check("tile_bank", 32'(tile_bank), 32'(exp_tbank));
        check("udswn", 32'(udswn), 32'(write_strobe_n(rnw, udsn)));
        check("ldswn", 32'(ldswn), 32'(write_strobe_n(rnw, ldsn)));
        check("cpu_addr", 32'(cpu_addr), 32'(addr[12:1]));
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test FAILED");
        $fatal(1);
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_board(byte_t id);
        game_id   = id;
        cur_board = board_class(id);
        tick();
        tick();
    endtask

    task automatic fill_memories();
        logic [31:0] r;
        r = lcg_next();
        ram_data = r[31:16];
        rom_data = r[15:0];
        r = lcg_next();
        char_dout = r[31:16];
        pal_dout  = r[15:0];
        r = lcg_next();
        obj_dout = r[31:16];
        cab_dout = r[7:0];
    endtask

    task automatic start_cycle(region_t act, addr_t a, logic rd, logic ds);
        cs_chk_en  = 1'b0;
        din_chk_en = 1'b0;
        active = act;
        addr   = a;
        rnw    = rd;
        asn    = 1'b0;
        udsn   = !ds;
        ldsn   = !ds;
    endtask

    task automatic end_cycle();
        cs_chk_en  = 1'b0;
        din_chk_en = 1'b0;
        asn    = 1'b1;
        udsn   = 1'b1;
        ldsn   = 1'b1;
        rnw    = 1'b1;
        active = '0;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        tick();
        exp_cs    = '0;
        cs_chk_en = 1'b1;
        tick();
    endtask

    task automatic read_cycle(region_t act, addr_t a, logic ds);
        fill_memories();
        start_cycle(act, a, 1'b1, ds);
        tick();
        exp_cs    = select_set(cur_board, act, a, 1'b1, ds);
        cs_chk_en = 1'b1;
        tick();
        exp_din    = read_data_for(exp_cs);
        din_chk_en = 1'b1;
        tick();
        end_cycle();
    endtask

    // Upper lane always strobed, lower lane only when low_lane is set
    task automatic write_tbank(region_t act, addr_t a, word_t data, logic low_lane);
        cpu_dout = data;
        start_cycle(act, a, 1'b0, 1'b1);
        ldsn = !low_lane;
        tick();
        exp_cs    = select_set(cur_board, act, a, 1'b0, 1'b1);
        cs_chk_en = 1'b1;
        tick();
        if (low_lane && tbank_write_hit(cur_board, act, a)) begin
            if (a[1]) exp_tbank[5:3] = data[2:0];
            else exp_tbank[2:0] = data[2:0];
        end
        tick();
        end_cycle();
    endtask

    // Holds the strobes until the DUT drops bus_busy
    task automatic busy_access(region_t act, addr_t a, logic is_rom, int wait_n);
        int n;
        start_cycle(act, a, 1'b1, 1'b1);
        tick();
        exp_busy    = 1'b1;
        busy_chk_en = 1'b1;
        // The other ok line must not end the access
        if (is_rom) ram_ok = 1'b1;
        else rom_ok = 1'b1;
        repeat (wait_n) tick();
        busy_chk_en = 1'b0;
        if (is_rom) rom_ok = 1'b1;
        else ram_ok = 1'b1;
        n = 0;
        while (bus_busy) begin
            tick();
            n = n + 1;
            if (n > 4) begin
                $display("bus_busy stayed high after the memory ok arrived");
                $display("Test FAILED");
                $fatal(1);
            end
        end
        end_cycle();
    endtask

    initial begin
        region_t     act;
        addr_t       a;
        logic [31:0] r;
        byte_t       ids [5];

        lcg_state = 32'd9494;
        err_count = 0;
        rst = 1'b1;
        game_id = 8'h00;
        addr = '0;
        active = '0;
        asn = 1'b1;
        udsn = 1'b1;
        ldsn = 1'b1;
        rnw = 1'b1;
        cpu_dout = '0;
        ram_data = '0;
        ram_ok = 1'b0;
        rom_data = '0;
        rom_ok = 1'b0;
        char_dout = '0;
        pal_dout = '0;
        obj_dout = '0;
        cab_dout = '0;
        exp_cs = '0;
        exp_din = '0;
        exp_rom = '0;
        exp_busy = 1'b0;
        exp_tbank = '0;
        cs_chk_en = 1'b0;
        din_chk_en = 1'b0;
        rom_chk_en = 1'b0;
        busy_chk_en = 1'b0;
        tbank_chk_en = 1'b0;
        cur_board = BOARD_5521;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // Idle state after reset
        cs_chk_en    = 1'b1;
        busy_chk_en  = 1'b1;
        tbank_chk_en = 1'b1;
        tick();
        tick();
        busy_chk_en = 1'b0;

        // ROM address mapping per board family
        ids = '{8'h00, 8'h11, 8'h15, 8'h20, 8'h08};
        foreach (ids[i]) begin
            set_board(ids[i]);
            repeat (12) begin
                r = lcg_next();
                act = '0;
                act[r[17:16] % 3] = 1'b1;
                r = lcg_next();
                a = r[22:0];
                active = act;
                addr = a;
                exp_rom = rom_word_addr(cur_board, act, a);
                rom_chk_en = 1'b1;
                tick();
            end
            rom_chk_en = 1'b0;
            active = '0;
        end

        // Chip selects and read data per region
        set_board(8'h00);
        for (int reg_n = 0; reg_n < 8; reg_n++) begin
            act = '0;
            act[reg_n] = 1'b1;
            r = lcg_next();
            a = r[22:0];
            a[16] = 1'b0;
            read_cycle(act, a, 1'b1);
            a[16] = 1'b1;
            read_cycle(act, a, 1'b1);
        end
        read_cycle('0, 23'h012345, 1'b1);
        // Address strobe only
        for (int reg_n = 3; reg_n < 8; reg_n++) begin
            act = '0;
            act[reg_n] = 1'b1;
            read_cycle(act, 23'h000100, 1'b0);
        end

        // Variable latency on SDRAM accesses
        for (int t = 0; t < 4; t++) begin
            r = lcg_next();
            busy_access(8'h01, r[22:0], 1'b1, int'(r[26:24] % 3'd7) + 1);
            r = lcg_next();
            busy_access(8'h08, r[22:0], 1'b0, int'(r[26:24]) + 1);
            r = lcg_next();
            a = r[22:0];
            a[16] = 1'b0;
            busy_access(8'h20, a, 1'b0, int'(r[28:26]) + 1);
        end

        // Tile bank writes and reads on 5521
        write_tbank(8'h04, 23'h000000, 16'h0005, 1'b1);
        write_tbank(8'h04, 23'h000001, 16'h0003, 1'b1);
        write_tbank(8'h04, 23'h000000, 16'h0007, 1'b0);
        read_cycle(8'h04, 23'h000000, 1'b1);
        read_cycle(8'h04, 23'h000001, 1'b1);

        // Same on 5797
        set_board(8'h20);
        write_tbank(8'h02, 23'h001000, 16'h0002, 1'b1);
        write_tbank(8'h02, 23'h001001, 16'h0006, 1'b1);
        write_tbank(8'h02, 23'h000801, 16'h0001, 1'b1);
        read_cycle(8'h02, 23'h001000, 1'b1);
        read_cycle(8'h02, 23'h001001, 1'b1);

        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/s16b_pkg.sv
rtl/s16b_board_map.sv
rtl/s16b_chip_select.sv
rtl/s16b_data_bus.sv
rtl/s16b_main.sv
sim/s16b_main_chk.sv
sim/tb_s16b_main.sv

//--- Makefile
TOP = tb_s16b_main

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^Test OK$$"

clean:
	rm -rf obj_dir
